// File: build.f
logic/mem_split_pkg.sv
logic/ft_fifo.sv
logic/bank_lane.sv
logic/split_ctrl.sv
logic/bank_sram.sv
logic/banked_mem_top.sv
tb/tb_banked_mem.sv

// File: Bender.yml
package:
  name: banked_mem

dependencies: {}

sources:
  - logic/mem_split_pkg.sv
  - logic/ft_fifo.sv
  - logic/bank_lane.sv
  - logic/split_ctrl.sv
  - logic/bank_sram.sv
  - logic/banked_mem_top.sv
  - target: test
    files:
      - tb/tb_banked_mem.sv

// File: tb/tb_banked_mem.sv
// ----------------------------------------------------------
// Testbench for the banked scratch memory.
// Shadow memory model, directed and random tests, and an
// in-order response checker.
// ----------------------------------------------------------
`timescale 1ns/1ps

module tb_banked_mem;

  import mem_split_pkg::*;

  localparam int unsigned Timeout = 200;
  localparam int unsigned IdxBits = $clog2(BankWords);
  localparam int unsigned OffBits = $clog2(DataBytes);

  // One expected response, with the edge that accepted it.
  typedef struct packed {
    logic                 we;
    logic [DataWidth-1:0] data;
    int unsigned          edge_n;
  } exp_t;

  logic                 clk_i;
  logic                 reset_i;
  logic                 req_i;
  mem_req_t             req_data_i;
  logic                 gnt_o;
  logic                 rvalid_o;
  logic [DataWidth-1:0] rdata_o;
  logic [NumBanks-1:0]  bank_stall_i;

  logic [DataWidth-1:0] shadow [BankWords];
  exp_t                 exp_q [$];
  int                   seed = 66666;
  int unsigned          cyc;
  int unsigned          errors;
  int unsigned          checks;
  int unsigned          responses;
  int unsigned          tests;
  bit                   check_latency;
  bit                   rand_stall;

  banked_mem_top banked_mem_top_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_i        (req_i),
    .req_data_i   (req_data_i),
    .gnt_o        (gnt_o),
    .rvalid_o     (rvalid_o),
    .rdata_o      (rdata_o),
    .bank_stall_i (bank_stall_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Rising edges since time zero.
  always @(posedge clk_i) begin
    cyc <= cyc + 1;
  end

  // Expected read data; a write also merges its bytes into the shadow.
  function automatic logic [DataWidth-1:0] ref_access(input mem_req_t r);
    logic [IdxBits-1:0]   idx;
    logic [DataWidth-1:0] word;
    idx  = r.addr[OffBits +: IdxBits];
    word = shadow[idx];
    if (r.we) begin
      for (int b = 0; b < DataBytes; b++) begin
        if (r.strb[b]) begin
          shadow[idx][b*8 +: 8] = r.wdata[b*8 +: 8];
        end
      end
    end
    return word;
  endfunction

  function automatic mem_req_t make_req(input logic we, input int unsigned idx,
                                        input logic [DataWidth-1:0] wdata,
                                        input logic [DataBytes-1:0] strb);
    mem_req_t r;
    r.addr  = AddrWidth'(idx * DataBytes);
    r.wdata = wdata;
    r.strb  = strb;
    r.we    = we;
    return r;
  endfunction

  // Initial contents; every bank slice carries the word index.
  function automatic logic [DataWidth-1:0] fill_word(input int unsigned idx);
    logic [BankBits-1:0] w;
    w = BankBits'(idx);
    return {16'hD000 | w, 16'hC000 | w, 16'hB000 | w, 16'hA000 | w};
  endfunction

  // Each bank stalls with probability one in four.
  function automatic logic [NumBanks-1:0] next_stall();
    logic [NumBanks-1:0] s;
    for (int i = 0; i < NumBanks; i++) begin
      s[i] = (($random(seed) & 3) == 0);
    end
    return s;
  endfunction

  // Present one request and hold it until it is granted.
  task automatic send(input mem_req_t r);
    int unsigned waited;
    bit          taken;
    exp_t        e;
    waited     = 0;
    taken      = 1'b0;
    req_i      = 1'b1;
    req_data_i = r;
    while (!taken && waited < Timeout) begin
      @(negedge clk_i);
      // Grant seen here means the coming edge accepts.
      if (gnt_o) begin
        taken    = 1'b1;
        e.we     = r.we;
        e.data   = ref_access(r);
        e.edge_n = cyc + 1;
        exp_q.push_back(e);
      end
      @(posedge clk_i);
      #1;
      if (rand_stall) begin
        bank_stall_i = next_stall();
      end
      waited++;
    end
    req_i = 1'b0;
    if (!taken) begin
      $display("ERROR request to address %h was never granted", r.addr);
      errors++;
    end
  endtask

  // Wait until every accepted request has answered.
  task automatic wait_drain();
    int unsigned waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < Timeout) begin
      @(posedge clk_i);
      #1;
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("ERROR %0d responses still missing after %0d cycles", exp_q.size(), Timeout);
      errors++;
      exp_q.delete();
    end
  endtask

  task automatic end_test(input string name, input int unsigned err_before);
    tests++;
    if (errors == err_before) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      $display("test %0d %s: %0d errors", tests, name, errors - err_before);
    end
  endtask

  // Responses are checked mid-cycle, in request order.
  always @(negedge clk_i) begin : compare
    exp_t e;
    if (!reset_i && rvalid_o) begin
      responses++;
      checks++;
      assert (exp_q.size() != 0) else begin
        $display("ERROR response arrived with no request outstanding");
        errors++;
      end
      if (exp_q.size() != 0) begin
        e = exp_q.pop_front();
        // Write responses carry no data.
        if (!e.we) begin
          checks++;
          assert (rdata_o === e.data) else begin
            $display("FAIL rdata_o got %h expected %h", rdata_o, e.data);
            errors++;
          end
        end
        if (check_latency) begin
          checks++;
          assert (cyc == e.edge_n) else begin
            $display("FAIL rvalid_o at cycle %h expected cycle %h", cyc, e.edge_n);
            errors++;
          end
        end
      end
    end
  end

  initial begin
    mem_req_t             r;
    int unsigned          err_start;
    int unsigned          resp_start;
    logic [DataWidth-1:0] wd;
    reset_i       = 1'b1;
    req_i         = 1'b0;
    req_data_i    = '0;
    bank_stall_i  = '0;
    check_latency = 1'b0;
    rand_stall    = 1'b0;
    repeat (10) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    // Idle state, then fill and read back every word.
    err_start     = errors;
    check_latency = 1'b1;
    @(negedge clk_i);
    checks += 2;
    assert (gnt_o === 1'b1) else begin
      $display("FAIL gnt_o got %h expected %h", gnt_o, 1'b1);
      errors++;
    end
    assert (rvalid_o === 1'b0) else begin
      $display("FAIL rvalid_o got %h expected %h", rvalid_o, 1'b0);
      errors++;
    end
    @(posedge clk_i);
    #1;
    for (int i = 0; i < BankWords; i++) begin
      send(make_req(1'b1, i, fill_word(i), '1));
    end
    for (int i = 0; i < BankWords; i++) begin
      send(make_req(1'b0, i, '0, '0));
    end
    send(make_req(1'b1, 9, 64'h0123_4567_89AB_CDEF, '1));
    send(make_req(1'b0, 9, '0, '0));
    wait_drain();
    end_test("full write and read", err_start);

    // Random partial strobes, each followed by a read.
    err_start = errors;
    for (int k = 0; k < 8; k++) begin
      wd = {$random(seed), $random(seed)};
      send(make_req(1'b1, 12 + (k & 1), wd, DataBytes'($random(seed))));
      send(make_req(1'b0, 12 + (k & 1), '0, '0));
    end
    wait_drain();
    end_test("partial strobes", err_start);

    // Bank 2 stalled; writes that skip it must still finish.
    err_start    = errors;
    bank_stall_i = 4'b0100;
    send(make_req(1'b1, 20, 64'hFEED_FACE_CAFE_BEEF, 8'hCF));
    send(make_req(1'b1, 21, 64'h5555_AAAA_5555_AAAA, 8'h00));
    wait_drain();
    bank_stall_i = '0;
    send(make_req(1'b0, 20, '0, '0));
    send(make_req(1'b0, 21, '0, '0));
    wait_drain();
    end_test("zero strobe writes", err_start);

    // Stalled bank fills its request FIFO and drops the grant.
    err_start     = errors;
    check_latency = 1'b0;
    bank_stall_i  = 4'b0010;
    for (int k = 0; k < FifoDepth; k++) begin
      send(make_req(k == 0, 30, 64'h0F0F_1E1E_2D2D_3C3C, '1));
    end
    @(negedge clk_i);
    checks++;
    assert (gnt_o === 1'b0) else begin
      $display("FAIL gnt_o got %h expected %h", gnt_o, 1'b0);
      errors++;
    end
    repeat (3) @(posedge clk_i);
    #1;
    checks++;
    assert (exp_q.size() == FifoDepth) else begin
      $display("ERROR responses arrived while a bank was stalled");
      errors++;
    end
    bank_stall_i = '0;
    wait_drain();
    end_test("stall back-pressure", err_start);

    // Random traffic under random stalls.
    err_start  = errors;
    resp_start = responses;
    rand_stall = 1'b1;
    for (int n = 0; n < 200; n++) begin
      r.addr  = AddrWidth'($random(seed)) & AddrWidth'(BankWords * DataBytes - 1);
      r.we    = $random(seed);
      r.wdata = {$random(seed), $random(seed)};
      r.strb  = $random(seed);
      if (($random(seed) & 3) == 0) begin
        r.strb = r.strb & ~(DataBytes'(3) << (BankBytes * ($random(seed) & 3)));
      end
      if (($random(seed) & 7) == 0) begin
        r.strb = '0;
      end
      send(r);
    end
    rand_stall   = 1'b0;
    bank_stall_i = '0;
    wait_drain();
    checks++;
    assert (responses - resp_start == 200) else begin
      $display("FAIL responses got %h expected %h", responses - resp_start, 200);
      errors++;
    end
    end_test("random traffic", err_start);

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: logic/banked_mem_top.sv
// ----------------------------------------------------------
// Banked scratch memory top level.
// Slices the wide request over the bank lanes and joins the
// lane responses into one in-order wide response.
// ----------------------------------------------------------
`timescale 1ns/1ps

module banked_mem_top (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                req_i,
  input  mem_split_pkg::mem_req_t             req_data_i,
  output logic                                gnt_o,
  output logic                                rvalid_o,
  output logic [mem_split_pkg::DataWidth-1:0] rdata_o,
  input  logic [mem_split_pkg::NumBanks-1:0]  bank_stall_i
);

  import mem_split_pkg::*;

  logic                 accept;
  logic [AddrWidth-1:0] addr_aligned;
  bank_req_t            req_slice     [NumBanks];
  bank_req_t            bank_req_data [NumBanks];
  bank_rsp_t            bank_rdata    [NumBanks];
  bank_rsp_t            resp_data     [NumBanks];
  logic [NumBanks-1:0]  lane_ready;
  logic [NumBanks-1:0]  resp_ready;
  logic [NumBanks-1:0]  resp_valid;
  logic [NumBanks-1:0]  pop;
  logic [NumBanks-1:0]  bank_req;
  logic [NumBanks-1:0]  bank_gnt;
  logic [NumBanks-1:0]  bank_rvalid;

  // Wide words are aligned to the full data width.
  assign addr_aligned = {req_data_i.addr[AddrWidth-1:$clog2(DataBytes)],
                         {$clog2(DataBytes){1'b0}}};

  split_ctrl split_ctrl_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_i        (req_i),
    .we_i         (req_data_i.we),
    .strb_i       (req_data_i.strb),
    .gnt_o        (gnt_o),
    .accept_o     (accept),
    .lane_ready_i (lane_ready),
    .resp_ready_i (resp_ready),
    .resp_valid_i (resp_valid),
    .pop_o        (pop),
    .rvalid_o     (rvalid_o)
  );

  for (genvar i = 0; i < NumBanks; i++) begin : gen_bank
    // This bank's share of the wide request.
    assign req_slice[i].addr  = addr_aligned + AddrWidth'(i * BankBytes);
    assign req_slice[i].wdata = req_data_i.wdata[i*BankBits +: BankBits];
    assign req_slice[i].strb  = req_data_i.strb[i*BankBytes +: BankBytes];
    assign req_slice[i].we    = req_data_i.we;

    bank_lane bank_lane_i (
      .clk_i           (clk_i),
      .reset_i         (reset_i),
      .accept_i        (accept),
      .req_slice_i     (req_slice[i]),
      .lane_ready_o    (lane_ready[i]),
      .bank_req_o      (bank_req[i]),
      .bank_req_data_o (bank_req_data[i]),
      .bank_gnt_i      (bank_gnt[i]),
      .bank_rvalid_i   (bank_rvalid[i]),
      .bank_rdata_i    (bank_rdata[i]),
      .resp_valid_o    (resp_valid[i]),
      .resp_data_o     (resp_data[i]),
      .resp_ready_o    (resp_ready[i]),
      .pop_i           (pop[i])
    );

    bank_sram bank_sram_i (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .stall_i    (bank_stall_i[i]),
      .req_i      (bank_req[i]),
      .req_data_i (bank_req_data[i]),
      .gnt_o      (bank_gnt[i]),
      .rvalid_o   (bank_rvalid[i]),
      .rdata_o    (bank_rdata[i])
    );

    // Lane data lands in its slot of the wide word.
    assign rdata_o[i*BankBits +: BankBits] = resp_data[i];
  end

endmodule

// File: logic/bank_sram.sv
// ----------------------------------------------------------
// Single bank memory with byte strobes.
// Stall input withholds the grant; responses are returned
// one cycle after each grant, for reads and writes alike.
// ----------------------------------------------------------
`timescale 1ns/1ps

module bank_sram (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     stall_i,
  input  logic                     req_i,
  input  mem_split_pkg::bank_req_t req_data_i,
  output logic                     gnt_o,
  output logic                     rvalid_o,
  output mem_split_pkg::bank_rsp_t rdata_o
);

  import mem_split_pkg::*;

  bank_rsp_t                      mem_q [BankWords];
  logic [$clog2(BankWords)-1:0]   idx;
  logic                           fire;

  // Word index sits above the wide-word byte offset.
  assign idx   = req_data_i.addr[$clog2(DataBytes) +: $clog2(BankWords)];
  assign gnt_o = ~stall_i;
  assign fire  = req_i & gnt_o;

  // Byte-wise write, read of the old word.
  always_ff @(posedge clk_i) begin
    if (fire) begin
      for (int b = 0; b < BankBytes; b++) begin
        if (req_data_i.we && req_data_i.strb[b]) begin
          mem_q[idx][b*8 +: 8] <= req_data_i.wdata[b*8 +: 8];
        end
      end
      rdata_o <= mem_q[idx];
    end
  end

  // One response pulse per granted request.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= fire;
    end
  end

endmodule

// File: logic/split_ctrl.sv
// ----------------------------------------------------------
// Split control for the banked memory.
// Grants the wide request, tracks writes that skip a bank,
// and merges the per-bank responses in order.
// ----------------------------------------------------------
`timescale 1ns/1ps

module split_ctrl (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  // Wide request handshake.
  input  logic                                 req_i,
  input  logic                                 we_i,
  input  logic [mem_split_pkg::DataBytes-1:0]  strb_i,
  output logic                                 gnt_o,
  output logic                                 accept_o,
  // Lane status.
  input  logic [mem_split_pkg::NumBanks-1:0]   lane_ready_i,
  input  logic [mem_split_pkg::NumBanks-1:0]   resp_ready_i,
  input  logic [mem_split_pkg::NumBanks-1:0]   resp_valid_i,
  // Merged response.
  output logic [mem_split_pkg::NumBanks-1:0]   pop_o,
  output logic                                 rvalid_o
);

  import mem_split_pkg::*;

  logic [NumBanks-1:0] dead_mask;
  logic [NumBanks-1:0] dead_head;
  logic [NumBanks-1:0] dead;
  logic                dead_full;
  logic                dead_empty;

  // Grant only when every lane can take the slice and its
  // response, and a dead mask slot is free.
  assign gnt_o    = (&lane_ready_i) & (&resp_ready_i) & ~dead_full;
  assign accept_o = req_i & gnt_o;

  // Banks that a write skips entirely.
  for (genvar i = 0; i < NumBanks; i++) begin : gen_dead_mask
    assign dead_mask[i] = we_i && (strb_i[i*BankBytes +: BankBytes] == '0);
  end

  // One mask per outstanding transaction, in request order.
  // Registered, so a mask shows up the cycle after accept.
  ft_fifo #(
    .Width       (NumBanks),
    .Depth       (MaxTrans + 1),
    .FallThrough (1'b0)
  ) dead_fifo_i (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (accept_o),
    .ready_o (),
    .data_i  (dead_mask),
    .valid_o (),
    .ready_i (rvalid_o),
    .data_o  (dead_head),
    .full_o  (dead_full),
    .empty_o (dead_empty)
  );

  // Stale head data is ignored while nothing is tracked.
  assign dead = dead_head & {NumBanks{~dead_empty}};

  // Complete once every bank answered or was skipped.
  assign rvalid_o = &(resp_valid_i | dead);

  // Only live banks hold a response to drop.
  assign pop_o = {NumBanks{rvalid_o}} & ~dead;

endmodule

// File: logic/bank_lane.sv
// ----------------------------------------------------------
// One bank's request and response path.
// Buffers the sliced request, hides zero-strobe writes from
// the bank, and buffers the bank's responses until merged.
// ----------------------------------------------------------
`timescale 1ns/1ps

module bank_lane (
  input  logic                     clk_i,
  input  logic                     reset_i,
  // Request slice from the wide port.
  input  logic                     accept_i,
  input  mem_split_pkg::bank_req_t req_slice_i,
  output logic                     lane_ready_o,
  // Bank memory request side.
  output logic                     bank_req_o,
  output mem_split_pkg::bank_req_t bank_req_data_o,
  input  logic                     bank_gnt_i,
  // Bank memory response side.
  input  logic                     bank_rvalid_i,
  input  mem_split_pkg::bank_rsp_t bank_rdata_i,
  // Buffered response toward the merge logic.
  output logic                     resp_valid_o,
  output mem_split_pkg::bank_rsp_t resp_data_o,
  output logic                     resp_ready_o,
  input  logic                     pop_i
);

  import mem_split_pkg::*;

  bank_req_t req_head;
  logic      req_valid;
  logic      req_gnt;
  logic      hide;

  // Request FIFO; fall-through so an idle bank sees the
  // request in the accepting cycle.
  ft_fifo #(
    .Width       ($bits(bank_req_t)),
    .Depth       (FifoDepth),
    .FallThrough (1'b1)
  ) req_fifo_i (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (accept_i),
    .ready_o (lane_ready_o),
    .data_i  (req_slice_i),
    .valid_o (req_valid),
    .ready_i (req_gnt),
    .data_o  (req_head),
    .full_o  (),
    .empty_o ()
  );

  // Write with no strobes in this bank is dropped here.
  // The control block accounts for its missing response.
  assign hide            = req_head.we && (req_head.strb == '0);
  assign bank_req_o      = req_valid & ~hide;
  assign req_gnt         = hide ? 1'b1 : bank_gnt_i;
  assign bank_req_data_o = req_head;

  // Response FIFO; the bank pushes without back-pressure.
  ft_fifo #(
    .Width       ($bits(bank_rsp_t)),
    .Depth       (FifoDepth),
    .FallThrough (1'b1)
  ) rsp_fifo_i (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (bank_rvalid_i),
    .ready_o (resp_ready_o),
    .data_i  (bank_rdata_i),
    .valid_o (resp_valid_o),
    .ready_i (pop_i),
    .data_o  (resp_data_o),
    .full_o  (),
    .empty_o ()
  );

endmodule

// File: logic/ft_fifo.sv
// ----------------------------------------------------------
// Stream FIFO with valid/ready handshakes on both sides.
// Circular buffer; optional fall-through when empty.
// ----------------------------------------------------------
`timescale 1ns/1ps

module ft_fifo #(
  parameter int unsigned Width       = 8,
  parameter int unsigned Depth       = 2,
  parameter bit          FallThrough = 1'b1
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             valid_i,
  output logic             ready_o,
  input  logic [Width-1:0] data_i,
  output logic             valid_o,
  input  logic             ready_i,
  output logic [Width-1:0] data_o,
  output logic             full_o,
  output logic             empty_o
);

  // Storage and pointers.
  logic [Width-1:0]             mem_q [Depth];
  logic [$clog2(Depth)-1:0]     wr_ptr_q;
  logic [$clog2(Depth)-1:0]     rd_ptr_q;
  logic [$clog2(Depth+1)-1:0]   count_q;
  logic                         push;
  logic                         pop;
  logic                         bypass;

  assign full_o  = (count_q == Depth);
  assign empty_o = (count_q == '0);

  // Empty fall-through FIFO hands the input straight on.
  assign bypass  = FallThrough && empty_o;
  assign ready_o = ~full_o;
  assign valid_o = bypass ? valid_i : ~empty_o;
  assign data_o  = bypass ? data_i : mem_q[rd_ptr_q];

  // A bypassed beat taken downstream is never stored.
  assign push = valid_i & ready_o & ~(bypass & ready_i);
  assign pop  = ready_i & ~empty_o;

  // Pointer and fill level bookkeeping.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == Depth - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == Depth - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop keep the level.
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Payload storage.
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// File: logic/mem_split_pkg.sv
// ----------------------------------------------------------
// Banked scratch memory package.
// Geometry constants and the wide and per-bank request and
// response types shared by the RTL and the testbench.
// ----------------------------------------------------------
package mem_split_pkg;

  // Wide port geometry.
  localparam int unsigned AddrWidth = 16;
  localparam int unsigned DataWidth = 64;
  localparam int unsigned NumBanks  = 4;
  localparam int unsigned DataBytes = DataWidth / 8;

  // Per-bank geometry.
  localparam int unsigned BankBits  = DataWidth / NumBanks;
  localparam int unsigned BankBytes = BankBits / 8;
  localparam int unsigned BankWords = 64;

  // Buffering.
  // Depth of every lane request and response FIFO.
  localparam int unsigned FifoDepth = 2;
  // Outstanding transactions tracked by the dead-write FIFO.
  localparam int unsigned MaxTrans  = 2;

  // Wide request as seen on the outside port.
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
    logic [DataBytes-1:0] strb;
    logic                 we;
  } mem_req_t;

  // One bank's slice of the wide request.
  // Address is already aligned and offset to this bank.
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic [BankBits-1:0]  wdata;
    logic [BankBytes-1:0] strb;
    logic                 we;
  } bank_req_t;

  // One bank's read data.
  typedef logic [BankBits-1:0] bank_rsp_t;

endpackage
